// File: slx_params.svh
//////////////////////////////
// Widths, fixed-point format, register map
// and logger constants for the servo core
//////////////////////////////

`ifndef SLX_PARAMS_SVH
`define SLX_PARAMS_SVH

//////////////////////////////
// Data widths
`define SLX_ADC_W      16      // Raw ADC sample
`define SLX_SIG_W      24      // Filtered signal
`define SLX_COEF_W     16      // Signed Q2.14 coefficient
`define SLX_COEF_FRAC  14      // Coefficient fraction bits
`define SLX_WORD_W     16      // Command bus and log word
`define SLX_DIN_W      3       // Digital input lines

//////////////////////////////
// Command register map
`define SLX_FW_VERSION   16'h0012  // Read-only version word
`define SLX_REG_VERSION  16'h0000
`define SLX_REG_CH_BASE  16'h0010  // Four registers per channel
`define SLX_REG_DROPS    16'h0020  // Logger drop count

//////////////////////////////
// Slow logger
`define SLX_LOG_CREDITS  4     // Max words in flight
`define SLX_REC_WORDS    5     // Words per record

`endif

// File: slx_pkg.sv
//////////////////////////////
// Shared types of the servo core
//////////////////////////////

`default_nettype none

`include "slx_params.svh"

package slx_pkg;

	//////////////////////////////
	// Sample and signal types

	typedef logic signed [`SLX_ADC_W-1:0]  adc_t;  // Raw ADC sample
	typedef logic signed [`SLX_SIG_W-1:0]  sig_t;  // After the IIR filter

	// Q2.14 filter coefficient
	typedef logic signed [`SLX_COEF_W-1:0] coef_t;

	//////////////////////////////
	// Bus and logger types

	typedef logic [`SLX_WORD_W-1:0] word_t; // Command and log word
	typedef logic [`SLX_DIN_W-1:0]  din_t;  // Digital inputs, bit 0 is ext ref

	// Slow logger FSM
	typedef enum logic {
		IDLE, // Waiting for a reference tick
		SEND  // Streaming the captured record
	} log_state_t;

endpackage

`default_nettype wire

// File: iir_coef_if.sv
//////////////////////////////
// Filter settings of one channel
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface iir_coef_if;
	import slx_pkg::*;

	logic  on; // Filter enable, bypass when low
	coef_t a1; // Feedback on y[n-1]
	coef_t b0; // Feedforward on x[n]
	coef_t b1; // Feedforward on x[n-1]

	// Register bank side
	modport source (output on, a1, b0, b1);

	// Filter side
	modport sink (input on, a1, b0, b1);

endinterface

`default_nettype wire

// File: ext_ref_cond.sv
//////////////////////////////
// External reference conditioning
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ext_ref_cond (
	input  logic clk1,
	input  logic arst_n,
	input  logic ref_in, // Asynchronous 10 MHz reference
	output logic tick    // One clk1 cycle per rising edge
);

	localparam int SYNC_N = 4; // Synchronizer depth

	logic [SYNC_N-1:0] sync; // sync[0] newest
	logic              rise; // Edge detect stage

	//////////////////////////////
	// Sync, edge detect, output register

	always_ff @(posedge clk1 or negedge arst_n) begin
		if (!arst_n) begin
			sync <= '0;
			rise <= 1'b0;
			tick <= 1'b0;
		end else begin
			sync <= {sync[SYNC_N-2:0], ref_in}; // Shift in
			// Newer stage high, older stage still low
			rise <= sync[SYNC_N-2] & ~sync[SYNC_N-1];
			tick <= rise; // Register
		end
	end

endmodule

`default_nettype wire

// File: cmd_regs.sv
//////////////////////////////
// Command register bank
// Write decode, filter settings, registered readback
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "slx_params.svh"

module cmd_regs (
	input  logic           clk1,
	input  logic           arst_n,
	input  logic           cmd_trig,  // Write strobe
	input  slx_pkg::word_t cmd_addr,
	input  slx_pkg::word_t cmd_data,
	input  slx_pkg::word_t drops,     // From the slow logger
	output slx_pkg::word_t cmd_rdata, // Registered readback
	iir_coef_if.source     coef0,
	iir_coef_if.source     coef1
);
	import slx_pkg::*;

	localparam int NUM_CH = 2;

	logic [NUM_CH-1:0] ch_on;          // Control bit 0 per channel
	coef_t             a1_r [NUM_CH];
	coef_t             b0_r [NUM_CH];
	coef_t             b1_r [NUM_CH];
	word_t             rd_mux;         // Next readback value

	// Address of register off in channel c
	function automatic word_t ch_addr(input int c, input int off);
		return `SLX_REG_CH_BASE + word_t'(4 * c + off);
	endfunction

	//////////////////////////////
	// Write decode

	always_ff @(posedge clk1 or negedge arst_n) begin
		if (!arst_n) begin
			ch_on <= '0; // Filters start bypassed
			for (int c = 0; c < NUM_CH; c++) begin
				a1_r[c] <= '0;
				b0_r[c] <= '0;
				b1_r[c] <= '0;
			end
		end else if (cmd_trig) begin
			for (int c = 0; c < NUM_CH; c++) begin
				if (cmd_addr == ch_addr(c, 0)) ch_on[c] <= cmd_data[0];
				if (cmd_addr == ch_addr(c, 1)) a1_r[c]  <= coef_t'(cmd_data);
				if (cmd_addr == ch_addr(c, 2)) b0_r[c]  <= coef_t'(cmd_data);
				if (cmd_addr == ch_addr(c, 3)) b1_r[c]  <= coef_t'(cmd_data);
			end
		end
	end

	//////////////////////////////
	// Readback

	always_comb begin
		rd_mux = '0; // Unmapped reads zero
		if (cmd_addr == `SLX_REG_VERSION) rd_mux = `SLX_FW_VERSION;
		if (cmd_addr == `SLX_REG_DROPS)   rd_mux = drops;
		for (int c = 0; c < NUM_CH; c++) begin
			if (cmd_addr == ch_addr(c, 0)) rd_mux = word_t'(ch_on[c]);
			if (cmd_addr == ch_addr(c, 1)) rd_mux = word_t'(a1_r[c]);
			if (cmd_addr == ch_addr(c, 2)) rd_mux = word_t'(b0_r[c]);
			if (cmd_addr == ch_addr(c, 3)) rd_mux = word_t'(b1_r[c]);
		end
	end

	always_ff @(posedge clk1 or negedge arst_n) begin
		if (!arst_n) cmd_rdata <= '0;
		else         cmd_rdata <= rd_mux; // One cycle after address
	end

	// Settings out to the filters
	assign coef0.on = ch_on[0];
	assign coef0.a1 = a1_r[0];
	assign coef0.b0 = b0_r[0];
	assign coef0.b1 = b1_r[0];
	assign coef1.on = ch_on[1];
	assign coef1.a1 = a1_r[1];
	assign coef1.b0 = b0_r[1];
	assign coef1.b1 = b1_r[1];

endmodule

`default_nettype wire

// File: iir_filter.sv
//////////////////////////////
// First-order IIR filter
// Bypass and output saturation
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "slx_params.svh"

module iir_filter (
	input  logic          clk1,
	input  logic          arst_n,
	input  logic          sample_valid, // New sample strobe
	input  slx_pkg::adc_t sample,
	iir_coef_if.sink      coef,
	output slx_pkg::sig_t filt          // Also y[n-1]
);
	import slx_pkg::*;

	localparam int SCALE = `SLX_SIG_W - `SLX_ADC_W;        // x256
	localparam int ACC_W = `SLX_COEF_W + `SLX_SIG_W + 2;   // Three products

	adc_t                    x_hist;  // x[n-1] raw
	sig_t                    x_now;   // x[n] scaled
	sig_t                    x_old;   // x[n-1] scaled
	logic signed [ACC_W-1:0] acc;
	logic signed [ACC_W-1:0] acc_sh;  // Back to signal scale
	logic                    fits;    // No overflow of 24 bits
	sig_t                    y_sat;
	sig_t                    y_next;

	//////////////////////////////
	// Multiply-accumulate

	always_comb begin
		x_now = {sample, {SCALE{1'b0}}};
		x_old = {x_hist, {SCALE{1'b0}}};
		acc = ACC_W'(coef.b0) * ACC_W'(x_now)
			+ ACC_W'(coef.b1) * ACC_W'(x_old)
			+ ACC_W'(coef.a1) * ACC_W'(filt);
		acc_sh = acc >>> `SLX_COEF_FRAC; // Drop Q2.14 fraction

		// Upper bits all equal to the sign bit
		fits = (acc_sh[ACC_W-1:`SLX_SIG_W-1] == '0)
			|| (acc_sh[ACC_W-1:`SLX_SIG_W-1] == '1);
		if (fits)
			y_sat = acc_sh[`SLX_SIG_W-1:0];
		else if (acc_sh[ACC_W-1])
			y_sat = {1'b1, {(`SLX_SIG_W-1){1'b0}}}; // Clip negative
		else
			y_sat = {1'b0, {(`SLX_SIG_W-1){1'b1}}}; // Clip positive

		y_next = coef.on ? y_sat : x_now; // Off means pass scaled input
	end

	//////////////////////////////
	// History, updated in both modes

	always_ff @(posedge clk1 or negedge arst_n) begin
		if (!arst_n) begin
			x_hist <= '0;
			filt   <= '0;
		end else if (sample_valid) begin
			x_hist <= sample;
			filt   <= y_next; // Visible the cycle after the strobe
		end
	end

endmodule

`default_nettype wire

// File: slow_logger.sv
//////////////////////////////
// Slow data logger
// Record capture, word serializer, credit counter
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "slx_params.svh"

module slow_logger (
	input  logic           clk1,
	input  logic           arst_n,
	input  logic           tick,       // Conditioned reference
	input  slx_pkg::sig_t  filt0,
	input  slx_pkg::sig_t  filt1,
	input  slx_pkg::din_t  din,
	input  logic           log_credit, // One credit back per pulse
	output logic           log_valid,
	output slx_pkg::word_t log_data,
	output slx_pkg::word_t drops       // Ticks lost during SEND
);
	import slx_pkg::*;

	localparam int IDX_W   = $clog2(`SLX_REC_WORDS);
	localparam int CRD_W   = $clog2(`SLX_LOG_CREDITS + 1);
	localparam int DIN_PAD = `SLX_WORD_W - `SLX_DIN_W;

	log_state_t       state;
	word_t            rec [`SLX_REC_WORDS]; // Captured record
	word_t            seq;                  // Next sequence number
	logic [IDX_W-1:0] idx;                  // Word being sent
	logic [CRD_W-1:0] credits;              // Free slots downstream
	sig_t             diff;
	logic             capture;
	logic             send;                 // Word goes out next cycle
	logic             last;

	assign diff    = filt0 - filt1; // 24-bit wrap
	assign capture = tick && (state == IDLE);
	assign send    = (state == SEND) && (credits != '0);
	assign last    = (idx == IDX_W'(`SLX_REC_WORDS - 1));

	//////////////////////////////
	// Record buffer

	always_ff @(posedge clk1) begin
		if (capture) begin
			rec[0] <= filt0[`SLX_SIG_W-1 -: `SLX_WORD_W]; // Top 16 bits
			rec[1] <= filt1[`SLX_SIG_W-1 -: `SLX_WORD_W];
			rec[2] <= diff[`SLX_SIG_W-1 -: `SLX_WORD_W];
			rec[3] <= {din, {DIN_PAD{1'b0}}};             // Inputs on top
			rec[4] <= seq;
		end
	end

	//////////////////////////////
	// FSM and serializer

	always_ff @(posedge clk1 or negedge arst_n) begin
		if (!arst_n) begin
			state     <= IDLE;
			idx       <= '0;
			seq       <= '0;
			drops     <= '0;
			log_valid <= 1'b0;
			log_data  <= '0;
		end else begin
			log_valid <= send;
			if (send) log_data <= rec[idx]; // Held while stalled
			case (state)
				IDLE: begin
					if (tick) begin
						state <= SEND;
						idx   <= '0;
						seq   <= seq + 1'b1;
					end
				end
				SEND: begin
					if (tick) drops <= drops + 1'b1; // Busy, tick lost
					if (send) begin
						idx <= idx + 1'b1;
						if (last) state <= IDLE; // Fifth word out
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Credits

	// Spent when a word is issued, returned by the consumer
	always_ff @(posedge clk1 or negedge arst_n) begin
		if (!arst_n)
			credits <= CRD_W'(`SLX_LOG_CREDITS);
		else
			credits <= credits - CRD_W'(send) + CRD_W'(log_credit);
	end

endmodule

`default_nettype wire

// File: slx_top.sv
//////////////////////////////
// Servo sensing and logging core
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module slx_top (
	input  logic           clk1,
	input  logic           arst_n,
	// Command bus
	input  logic           cmd_trig,
	input  slx_pkg::word_t cmd_addr,
	input  slx_pkg::word_t cmd_data,
	output slx_pkg::word_t cmd_rdata,
	// ADC samples
	input  logic           adc_valid,
	input  slx_pkg::adc_t  adc0,
	input  slx_pkg::adc_t  adc1,
	// Digital inputs, bit 0 is the ext reference
	input  slx_pkg::din_t  din,
	// Log stream
	output logic           log_valid,
	output slx_pkg::word_t log_data,
	input  logic           log_credit
);
	import slx_pkg::*;

	sig_t  filt0;  // Channel 0 filtered
	sig_t  filt1;  // Channel 1 filtered
	word_t drops;  // Logger drop count for readback
	logic  tick;   // One cycle per reference edge

	iir_coef_if coef0_if ();
	iir_coef_if coef1_if ();

	//////////////////////////////
	// Configuration registers

	cmd_regs u_regs (
		.clk1      (clk1),
		.arst_n    (arst_n),
		.cmd_trig  (cmd_trig),
		.cmd_addr  (cmd_addr),
		.cmd_data  (cmd_data),
		.drops     (drops),
		.cmd_rdata (cmd_rdata),
		.coef0     (coef0_if),
		.coef1     (coef1_if)
	);

	//////////////////////////////
	// ADC filters

	iir_filter u_iir0 (
		.clk1         (clk1),
		.arst_n       (arst_n),
		.sample_valid (adc_valid),
		.sample       (adc0),
		.coef         (coef0_if),
		.filt         (filt0)
	);

	iir_filter u_iir1 (
		.clk1         (clk1),
		.arst_n       (arst_n),
		.sample_valid (adc_valid),
		.sample       (adc1),
		.coef         (coef1_if),
		.filt         (filt1)
	);

	//////////////////////////////
	// Reference tick and logger

	ext_ref_cond u_ref (
		.clk1   (clk1),
		.arst_n (arst_n),
		.ref_in (din[0]),
		.tick   (tick)
	);

	slow_logger u_log (
		.clk1       (clk1),
		.arst_n     (arst_n),
		.tick       (tick),
		.filt0      (filt0),
		.filt1      (filt1),
		.din        (din),
		.log_credit (log_credit),
		.log_valid  (log_valid),
		.log_data   (log_data),
		.drops      (drops)
	);

endmodule

`default_nettype wire

// File: tb_slx.sv
//////////////////////////////
// Testbench for the servo core
// Stimulus table, filter and record model
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "slx_params.svh"

module tb_slx;

	localparam int N_ENT = 5;
	localparam int LIMIT = N_ENT * 300 + 60 + 3; // Per-entry bound, setup, reset
	localparam longint Y_MAX = 64'sd8388607;     // 24-bit signed range
	localparam longint Y_MIN = -64'sd8388608;

	typedef struct packed {
		logic        on0, on1;
		logic [15:0] a1_0, b0_0, b1_0;
		logic [15:0] a1_1, b0_1, b1_1;
		logic [63:0] s0, s1;  // Four samples, first in the top bits
		logic [2:0]  din;
		logic [3:0]  extra;   // Ticks raised during a stalled record
	} entry_t;

	logic clk1 = 1'b0, arst_n = 1'b0, cmd_trig = 1'b0, adc_valid = 1'b0, log_credit = 1'b0;
	logic [15:0] cmd_addr = '0, cmd_data = '0, adc0 = '0, adc1 = '0;
	logic [2:0]  din = '0;
	logic [15:0] cmd_rdata, log_data;
	logic        log_valid;
	logic        hold = 1'b0;                     // Withhold credits
	logic [15:0] seq_exp = '0, drops_exp = '0;
	logic [15:0] got [$];                         // Words seen on the stream
	longint      xh [2], yh [2];                  // Model history per channel
	int          outstanding, value_errs, other_errs, cycles;
	entry_t      tbl [N_ENT];

	slx_top dut0 (.*);

	always #10 clk1 = ~clk1;

	//////////////////////////////
	// Helpers

	task automatic report_value(input string name, input logic [15:0] expv, actv);
		value_errs++;
		$display("error %s: expected %h, actual %h", name, expv, actv);
	endtask

	function automatic longint sint(input logic [15:0] v);
		return longint'($signed(v));
	endfunction

	// y[n] from the filter rules, Q2.14 coefficients
	function automatic longint filt_model(input logic on, input longint a1, b0, b1, x, xp, yp);
		longint acc;
		if (!on) return x <<< 8; // Bypass, x*256
		acc = (((b0 * x) <<< 8) + ((b1 * xp) <<< 8) + a1 * yp) >>> 14;
		if (acc > Y_MAX) acc = Y_MAX;
		else if (acc < Y_MIN) acc = Y_MIN;
		return acc;
	endfunction

	function automatic logic [15:0] top16(input longint v);
		logic [23:0] t;
		t = v[23:0]; // 24-bit wrap
		return t[23:8];
	endfunction

	task automatic write_reg(input logic [15:0] addr, data);
		@(negedge clk1);
		cmd_trig = 1'b1;
		cmd_addr = addr;
		cmd_data = data;
		@(negedge clk1);
		cmd_trig = 1'b0;
	endtask

	task automatic read_reg(input logic [15:0] addr, expv);
		@(negedge clk1);
		cmd_addr = addr;
		@(negedge clk1); // Registered one cycle later
		if (cmd_rdata !== expv) report_value($sformatf("cmd_rdata@%h", addr), expv, cmd_rdata);
	endtask

	task automatic wait_words(input int n);
		while (got.size() < n) @(posedge clk1);
	endtask

	//////////////////////////////
	// Stream monitor and credit return

	always @(negedge clk1) begin
		log_credit = 1'b0;
		if (arst_n && log_valid) begin
			got.push_back(log_data);
			outstanding++;
			if (outstanding > `SLX_LOG_CREDITS) begin
				other_errs++;
				$display("Logger sent more words than it had credits for");
			end
		end
		// Random gaps between returned credits
		if (!hold && outstanding > 0 && $urandom_range(2, 0) == 0) begin
			log_credit = 1'b1;
			outstanding--;
		end
	end

	always @(posedge clk1) begin
		cycles++;
		if (cycles > LIMIT) begin
			$display("Timeout after %0d cycles waiting for log words", LIMIT);
			$display("Verification failed");
			$finish;
		end
	end

	//////////////////////////////
	// One table entry

	task automatic run_entry(input int i);
		entry_t      e;
		logic        on [2];
		logic [15:0] a1 [2], b0 [2], b1 [2], x [2], expw [5];
		logic [15:0] base;
		logic [2:0]  dval;
		e = tbl[i];
		on = '{e.on0, e.on1};
		a1 = '{e.a1_0, e.a1_1};
		b0 = '{e.b0_0, e.b0_1};
		b1 = '{e.b1_0, e.b1_1};
		for (int c = 0; c < 2; c++) begin
			base = `SLX_REG_CH_BASE + 16'(4 * c);
			write_reg(base, {15'b0, on[c]});
			write_reg(base + 16'd1, a1[c]);
			write_reg(base + 16'd2, b0[c]);
			write_reg(base + 16'd3, b1[c]);
			read_reg(base, {15'b0, on[c]});
			read_reg(base + 16'd1, a1[c]);
			read_reg(base + 16'd2, b0[c]);
			read_reg(base + 16'd3, b1[c]);
		end
		for (int k = 0; k < 4; k++) begin
			x[0] = e.s0[63 - 16 * k -: 16];
			x[1] = e.s1[63 - 16 * k -: 16];
			for (int c = 0; c < 2; c++) begin
				yh[c] = filt_model(on[c], sint(a1[c]), sint(b0[c]), sint(b1[c]),
					sint(x[c]), xh[c], yh[c]);
				xh[c] = sint(x[c]);
			end
			@(negedge clk1);
			adc_valid = 1'b1;
			adc0 = x[0];
			adc1 = x[1];
		end
		@(negedge clk1);
		adc_valid = 1'b0;

		dval = e.din | 3'b001; // Bit 0 carries the reference edge
		expw = '{top16(yh[0]), top16(yh[1]), top16(yh[0] - yh[1]), {dval, 13'b0}, seq_exp};
		seq_exp = seq_exp + 16'd1;
		@(posedge clk1);
		hold = (e.extra != 4'd0);
		@(negedge clk1);
		din = dval;
		if (e.extra != 4'd0) begin
			wait_words(4); // All credits spent
			repeat (10) @(posedge clk1);
			if (got.size() != 4) begin
				other_errs++;
				$display("Logger sent a word with no credit left");
			end
			for (int t = 0; t < int'(e.extra); t++) begin
				@(negedge clk1);
				din = dval & 3'b110;
				repeat (4) @(negedge clk1);
				din = dval; // Extra edge, should be dropped
				repeat (3) @(negedge clk1);
			end
			drops_exp = drops_exp + 16'(e.extra);
			repeat (12) @(posedge clk1);
			hold = 1'b0;
		end
		wait_words(5);
		for (int w = 0; w < 5; w++)
			if (got[w] !== expw[w]) report_value($sformatf("log_data word %0d", w), expw[w], got[w]);
		got.delete();
		while (outstanding != 0) @(posedge clk1);
		@(negedge clk1);
		din = 3'b000;
		repeat (8) @(negedge clk1); // Let the synchronizer settle
		// Dropped edges must not start a record of their own
		if (got.size() != 0) begin
			other_errs++;
			$display("Logger sent words for a dropped reference edge");
			got.delete();
		end
	endtask

	//////////////////////////////
	// Main sequence

	initial begin
		void'($urandom(2862));
		// Bypass, bypass with difference wrap, filter, saturation, stall with drops
		tbl[0] = '{1'b0, 1'b0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0,
			{16'h1234, 16'h0100, 16'hff00, 16'h4321},
			{16'h0010, 16'h2000, 16'h8001, 16'h1000}, 3'b010, 4'd0};
		tbl[1] = '{1'b0, 1'b0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0,
			{16'h0001, 16'h0002, 16'h0003, 16'h7fff},
			{16'hfffe, 16'h0005, 16'h0006, 16'h8000}, 3'b100, 4'd0};
		tbl[2] = '{1'b1, 1'b1, 16'h0000, 16'h2000, 16'h2000, 16'h3000, 16'h1000, 16'h0000,
			{16'h1000, 16'h2000, 16'h3000, 16'h0800},
			{16'h4000, 16'h4000, 16'hc000, 16'h0400}, 3'b110, 4'd0};
		tbl[3] = '{1'b1, 1'b1, 16'h2000, 16'h7fff, 16'h7fff, 16'h2000, 16'h7fff, 16'h7fff,
			{4{16'h7000}}, {4{16'h9000}}, 3'b000, 4'd0};
		tbl[4] = '{1'b1, 1'b1, 16'h0000, 16'h4000, 16'h0000, 16'hf000, 16'h0000, 16'h4000,
			{16'h0123, 16'h0456, 16'h0789, 16'h0abc},
			{16'hfedc, 16'hba98, 16'h7654, 16'h3210}, 3'b011, 4'd3};
		repeat (3) @(posedge clk1);
		@(negedge clk1);
		arst_n = 1'b1;
		if (log_valid !== 1'b0) report_value("log_valid", 16'h0, {15'b0, log_valid});
		if (cmd_rdata !== 16'h0) report_value("cmd_rdata", 16'h0, cmd_rdata);
		read_reg(`SLX_REG_VERSION, `SLX_FW_VERSION);
		read_reg(16'h0001, 16'h0000); // Unmapped
		read_reg(16'h0018, 16'h0000);
		read_reg(16'hffff, 16'h0000);
		for (int i = 0; i < N_ENT; i++) run_entry(i);
		read_reg(`SLX_REG_DROPS, drops_exp);
		$display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
		if (value_errs + other_errs == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
slx_pkg.sv
iir_coef_if.sv
ext_ref_cond.sv
cmd_regs.sv
iir_filter.sv
slow_logger.sv
slx_top.sv
tb_slx.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_slx
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
